// File: rv_pkg.sv
`default_nettype none

package rv_pkg;

  // major opcodes, inst[6:0]
  localparam logic [6:0] opc_lui    = 7'b01_101_11;
  localparam logic [6:0] opc_auipc  = 7'b00_101_11;
  localparam logic [6:0] opc_jal    = 7'b11_011_11;
  localparam logic [6:0] opc_jalr   = 7'b11_001_11;
  localparam logic [6:0] opc_branch = 7'b11_000_11;
  localparam logic [6:0] opc_load   = 7'b00_000_11;
  localparam logic [6:0] opc_store  = 7'b01_000_11;
  localparam logic [6:0] opc_op_imm = 7'b00_100_11;
  localparam logic [6:0] opc_op     = 7'b01_100_11;
  localparam logic [6:0] opc_system = 7'b11_100_11;

  // machine csr addresses
  localparam logic [11:0] csr_mtvec  = 12'h305;
  localparam logic [11:0] csr_mepc   = 12'h341;
  localparam logic [11:0] csr_mcause = 12'h342;

  // alu operations, the csr ops take a = rs1 value and b = old csr value
  typedef enum logic [4:0] {
    alu_add,
    alu_sub,
    alu_sll,
    alu_slt,
    alu_sltu,
    alu_xor,
    alu_srl,
    alu_sra,
    alu_or,
    alu_and,
    alu_eq,
    alu_ne,
    alu_lt,
    alu_ge,
    alu_ltu,
    alu_geu,
    alu_csr_set,
    alu_csr_clear
  } alu_op_e;

  // next pc source
  typedef enum logic [2:0] {
    npc_seq,
    npc_jal,
    npc_jalr,
    npc_branch,
    npc_trap,
    npc_mret
  } npc_sel_e;

  // register write-back source
  typedef enum logic [2:0] {
    wb_alu,
    wb_pc4,
    wb_load,
    wb_auipc,
    wb_csr
  } wb_sel_e;

  // second alu operand
  typedef enum logic [1:0] {
    op2_rs2,
    op2_imm,
    op2_csr
  } op2_sel_e;

endpackage

`default_nettype wire

// File: rv_alu.sv
`timescale 1ns/100ps
`default_nettype none

module rv_alu
  import rv_pkg::*;
(
  input  logic [31:0] a,
  input  logic [31:0] b,
  input  alu_op_e     op,
  output logic [31:0] result,
  output logic        taken
);

  logic [4:0] shamt;
  logic       equal;
  logic       less_s;
  logic       less_u;

  assign shamt  = b[4:0];
  assign equal  = a == b;
  assign less_s = $signed(a) < $signed(b);
  assign less_u = a < b;

  // branch condition
  always_comb begin
    case (op)
      alu_eq:  taken = equal;
      alu_ne:  taken = ~equal;
      alu_lt:  taken = less_s;
      alu_ge:  taken = ~less_s;
      alu_ltu: taken = less_u;
      alu_geu: taken = ~less_u;
      default: taken = 1'b0;
    endcase
  end

  always_comb begin
    case (op)
      alu_add:       result = a + b;
      alu_sub:       result = a - b;
      alu_sll:       result = a << shamt;
      alu_slt:       result = {31'd0, less_s};
      alu_sltu:      result = {31'd0, less_u};
      alu_xor:       result = a ^ b;
      alu_srl:       result = a >> shamt;
      alu_sra:       result = $unsigned($signed(a) >>> shamt);
      alu_or:        result = a | b;
      alu_and:       result = a & b;
      alu_csr_set:   result = b | a;
      // b holds the old csr value, a the mask from rs1
      alu_csr_clear: result = b & ~a;
      // compares only report the condition
      default:       result = {31'd0, taken};
    endcase
  end

endmodule

`default_nettype wire

// File: rv_regfile.sv
`timescale 1ns/100ps
`default_nettype none

module rv_regfile (
  input  logic        clock,
  input  logic        reset,
  input  logic [4:0]  rs1,
  input  logic [4:0]  rs2,
  input  logic [4:0]  rd,
  input  logic        wen,
  input  logic [31:0] wdata,
  output logic [31:0] rdata1,
  output logic [31:0] rdata2
);

  logic [31:0] regs [32];

  always_ff @(posedge clock) begin
    if (reset) begin
      for (int i = 0; i < 32; i++) begin
        regs[i] <= 32'd0;
      end
    end else if (wen && rd != 5'd0) begin
      regs[rd] <= wdata;
    end
  end

  // x0 reads zero whatever the array holds
  assign rdata1 = (rs1 == 5'd0) ? 32'd0 : regs[rs1];
  assign rdata2 = (rs2 == 5'd0) ? 32'd0 : regs[rs2];

endmodule

`default_nettype wire

// File: rv_csr.sv
`timescale 1ns/100ps
`default_nettype none

module rv_csr
  import rv_pkg::*;
#(
  parameter logic [31:0] reset_mtvec = 32'h0000_0000
) (
  input  logic        clock,
  input  logic        reset,
  input  logic [11:0] addr,
  input  logic        wen,
  input  logic [31:0] wdata,
  input  logic        trap,
  input  logic [31:0] trap_pc,
  output logic [31:0] rdata,
  output logic [31:0] mtvec,
  output logic [31:0] mepc
);

  // environment call from machine mode
  localparam logic [31:0] cause_ecall_m = 32'd11;

  logic [31:0] mcause;

  always_ff @(posedge clock) begin
    if (reset) begin
      mtvec  <= reset_mtvec;
      mepc   <= 32'd0;
      mcause <= 32'd0;
    end else if (trap) begin
      mepc   <= trap_pc;
      mcause <= cause_ecall_m;
    end else if (wen) begin
      case (addr)
        csr_mtvec:  mtvec  <= wdata;
        csr_mepc:   mepc   <= wdata;
        csr_mcause: mcause <= wdata;
        default:    ;
      endcase
    end
  end

  // unknown addresses read zero
  always_comb begin
    case (addr)
      csr_mtvec:  rdata = mtvec;
      csr_mepc:   rdata = mepc;
      csr_mcause: rdata = mcause;
      default:    rdata = 32'd0;
    endcase
  end

endmodule

`default_nettype wire

// File: rv_lsu.sv
`timescale 1ns/100ps
`default_nettype none

module rv_lsu (
  input  logic [31:0] addr,
  input  logic [1:0]  size,
  input  logic        load_signed,
  input  logic [31:0] store_data,
  input  logic [31:0] mem_rdata,
  output logic [3:0]  wstrb,
  output logic [31:0] wdata,
  output logic [31:0] load_data
);

  logic [1:0]  offset;
  logic [31:0] lane;

  // address bits below the access size are dropped
  always_comb begin
    case (size)
      2'd0: begin
        offset = addr[1:0];
        wstrb  = 4'b0001 << addr[1:0];
        wdata  = {4{store_data[7:0]}};
      end
      2'd1: begin
        offset = {addr[1], 1'b0};
        wstrb  = addr[1] ? 4'b1100 : 4'b0011;
        wdata  = {2{store_data[15:0]}};
      end
      default: begin
        offset = 2'd0;
        wstrb  = 4'b1111;
        wdata  = store_data;
      end
    endcase
  end

  // move the addressed lane down to bit 0
  assign lane = mem_rdata >> {offset, 3'b000};

  always_comb begin
    case (size)
      2'd0:    load_data = {{24{load_signed & lane[7]}}, lane[7:0]};
      2'd1:    load_data = {{16{load_signed & lane[15]}}, lane[15:0]};
      default: load_data = lane;
    endcase
  end

endmodule

`default_nettype wire

// File: rv_idu.sv
`timescale 1ns/100ps
`default_nettype none

module rv_idu
  import rv_pkg::*;
(
  input  logic [31:0] inst,
  input  logic        ivalid,
  output logic [31:0] imm,
  output logic [4:0]  rs1,
  output logic [4:0]  rs2,
  output logic [4:0]  rd,
  output logic        r_wen,
  output wb_sel_e     wb_sel,
  output op2_sel_e    op2_sel,
  output alu_op_e     alu_op,
  output npc_sel_e    npc_sel,
  output logic        mem_ren,
  output logic        mem_wen,
  output logic [1:0]  mem_size,
  output logic        load_signed,
  output logic [11:0] csr_addr,
  output logic        csr_wen,
  output logic        trap,
  output logic        halt_req
);

  logic [6:0] opcode;
  logic [2:0] funct3;
  logic [6:0] funct7;
  logic       f7_zero;
  logic       f7_alt;

  logic is_lui;
  logic is_auipc;
  logic is_jal;
  logic is_jalr;
  logic is_branch;
  logic is_load;
  logic is_store;
  logic is_op_imm;
  logic is_op;
  logic is_csr;
  logic is_ecall;
  logic is_ebreak;
  logic is_mret;

  assign opcode  = inst[6:0];
  assign funct3  = inst[14:12];
  assign funct7  = inst[31:25];
  assign f7_zero = funct7 == 7'b00000_00;
  assign f7_alt  = funct7 == 7'b01000_00;

  assign is_lui    = opcode == opc_lui;
  assign is_auipc  = opcode == opc_auipc;
  assign is_jal    = opcode == opc_jal;
  assign is_jalr   = opcode == opc_jalr && funct3 == 3'b000;
  // funct3 010 and 011 are not branches
  assign is_branch = opcode == opc_branch && funct3[2:1] != 2'b01;
  assign is_load   = opcode == opc_load &&
                     (funct3 == 3'b000 || funct3 == 3'b001 || funct3 == 3'b010 ||
                      funct3 == 3'b100 || funct3 == 3'b101);
  assign is_store  = opcode == opc_store && funct3[2] == 1'b0 && funct3[1:0] != 2'b11;

  // shifts by immediate carry their own funct7
  assign is_op_imm = opcode == opc_op_imm &&
                     (funct3 == 3'b001 ? f7_zero :
                      funct3 == 3'b101 ? (f7_zero || f7_alt) : 1'b1);
  // sub and sra are the only alternate encodings, rv32m is not decoded
  assign is_op     = opcode == opc_op &&
                     (f7_zero || (f7_alt && (funct3 == 3'b000 || funct3 == 3'b101)));

  assign is_csr    = opcode == opc_system && funct3 != 3'b000 && funct3[2] == 1'b0;
  assign is_ecall  = inst == 32'b0000000_00000_00000_000_00000_11100_11;
  assign is_ebreak = inst == 32'b0000000_00001_00000_000_00000_11100_11;
  assign is_mret   = inst == 32'b0011000_00010_00000_000_00000_11100_11;

  // immediate by format
  always_comb begin
    if (is_lui || is_auipc) begin
      imm = {inst[31:12], 12'b0};
    end else if (is_jal) begin
      imm = {{12{inst[31]}}, inst[19:12], inst[20], inst[30:21], 1'b0};
    end else if (is_branch) begin
      imm = {{20{inst[31]}}, inst[7], inst[30:25], inst[11:8], 1'b0};
    end else if (is_store) begin
      imm = {{20{inst[31]}}, inst[31:25], inst[11:7]};
    end else begin
      imm = {{20{inst[31]}}, inst[31:20]};
    end
  end

  // lui reads x0 so that the add yields imm, csrrw reads x0 so rs1 passes through
  assign rs1 = is_lui ? 5'd0 : inst[19:15];
  assign rs2 = (is_csr && funct3 == 3'b001) ? 5'd0 : inst[24:20];
  assign rd  = inst[11:7];

  always_comb begin
    alu_op = alu_add;
    if (is_op || is_op_imm) begin
      case (funct3)
        3'b000:  alu_op = (is_op && f7_alt) ? alu_sub : alu_add;
        3'b001:  alu_op = alu_sll;
        3'b010:  alu_op = alu_slt;
        3'b011:  alu_op = alu_sltu;
        3'b100:  alu_op = alu_xor;
        3'b101:  alu_op = f7_alt ? alu_sra : alu_srl;
        3'b110:  alu_op = alu_or;
        default: alu_op = alu_and;
      endcase
    end else if (is_branch) begin
      case (funct3)
        3'b000:  alu_op = alu_eq;
        3'b001:  alu_op = alu_ne;
        3'b100:  alu_op = alu_lt;
        3'b101:  alu_op = alu_ge;
        3'b110:  alu_op = alu_ltu;
        default: alu_op = alu_geu;
      endcase
    end else if (is_csr) begin
      case (funct3)
        3'b010:  alu_op = alu_csr_set;
        3'b011:  alu_op = alu_csr_clear;
        default: alu_op = alu_add;
      endcase
    end
  end

  always_comb begin
    op2_sel = op2_rs2;
    if (is_lui || is_jalr || is_load || is_store || is_op_imm) begin
      op2_sel = op2_imm;
    end else if (is_csr && funct3 != 3'b001) begin
      op2_sel = op2_csr;
    end
  end

  always_comb begin
    npc_sel = npc_seq;
    if (is_jal)         npc_sel = npc_jal;
    else if (is_jalr)   npc_sel = npc_jalr;
    else if (is_branch) npc_sel = npc_branch;
    else if (is_ecall)  npc_sel = npc_trap;
    else if (is_mret)   npc_sel = npc_mret;
  end

  always_comb begin
    wb_sel = wb_alu;
    if (is_jal || is_jalr) wb_sel = wb_pc4;
    else if (is_load)      wb_sel = wb_load;
    else if (is_auipc)     wb_sel = wb_auipc;
    else if (is_csr)       wb_sel = wb_csr;
  end

  assign csr_addr = inst[31:20];

  assign mem_size    = funct3[1:0];
  assign load_signed = ~funct3[2];

  // every enable is qualified by ivalid
  assign r_wen    = (is_lui || is_auipc || is_jal || is_jalr || is_load ||
                     is_op_imm || is_op || is_csr) && ivalid;
  assign mem_ren  = is_load && ivalid;
  assign mem_wen  = is_store && ivalid;
  assign csr_wen  = is_csr && ivalid;
  assign trap     = is_ecall && ivalid;
  assign halt_req = is_ebreak && ivalid;

endmodule

`default_nettype wire

// File: rv_core.sv
`timescale 1ns/100ps
`default_nettype none

module rv_core
  import rv_pkg::*;
#(
  parameter logic [31:0] reset_pc        = 32'h0000_0000,
  parameter logic [31:0] csr_reset_mtvec = 32'h0000_0100
) (
  input  logic        clock,
  input  logic        reset,
  output logic [31:0] imem_addr,
  input  logic [31:0] imem_data,
  output logic [31:0] dmem_addr,
  output logic        dmem_re,
  input  logic [31:0] dmem_rdata,
  output logic        dmem_we,
  output logic [3:0]  dmem_wstrb,
  output logic [31:0] dmem_wdata,
  output logic        halted
);

  logic [31:0] pc;
  logic [31:0] pc_next;
  logic [31:0] pc_plus4;
  logic [31:0] pc_plus_imm;
  logic        ivalid;

  logic [31:0] imm;
  logic [4:0]  rs1;
  logic [4:0]  rs2;
  logic [4:0]  rd;
  logic        r_wen;
  wb_sel_e     wb_sel;
  op2_sel_e    op2_sel;
  alu_op_e     alu_op;
  npc_sel_e    npc_sel;
  logic        mem_ren;
  logic        mem_wen;
  logic [1:0]  mem_size;
  logic        load_signed;
  logic [11:0] csr_addr;
  logic        csr_wen;
  logic        trap;
  logic        halt_req;

  logic [31:0] rdata1;
  logic [31:0] rdata2;
  logic [31:0] op2;
  logic [31:0] alu_result;
  logic        taken;
  logic [31:0] wb_data;
  logic [31:0] csr_rdata;
  logic [31:0] mtvec;
  logic [31:0] mepc;
  logic [31:0] load_data;
  logic [3:0]  lsu_wstrb;

  assign ivalid      = ~halted;
  assign pc_plus4    = pc + 32'd4;
  // shared by auipc, jal and taken branches
  assign pc_plus_imm = pc + imm;

  // the pc stays on the ebreak once the core halts
  always_ff @(posedge clock) begin
    if (reset) begin
      pc     <= reset_pc;
      halted <= 1'b0;
    end else if (ivalid) begin
      if (halt_req) halted <= 1'b1;
      else          pc     <= pc_next;
    end
  end

  rv_idu u_idu (
    .inst(imem_data), .ivalid(ivalid), .imm(imm), .rs1(rs1), .rs2(rs2), .rd(rd),
    .r_wen(r_wen), .wb_sel(wb_sel), .op2_sel(op2_sel), .alu_op(alu_op), .npc_sel(npc_sel),
    .mem_ren(mem_ren), .mem_wen(mem_wen), .mem_size(mem_size), .load_signed(load_signed),
    .csr_addr(csr_addr), .csr_wen(csr_wen), .trap(trap), .halt_req(halt_req)
  );

  rv_regfile u_regfile (
    .clock(clock), .reset(reset), .rs1(rs1), .rs2(rs2), .rd(rd), .wen(r_wen),
    .wdata(wb_data), .rdata1(rdata1), .rdata2(rdata2)
  );

  always_comb begin
    case (op2_sel)
      op2_imm: op2 = imm;
      op2_csr: op2 = csr_rdata;
      default: op2 = rdata2;
    endcase
  end

  rv_alu u_alu (.a(rdata1), .b(op2), .op(alu_op), .result(alu_result), .taken(taken));

  rv_csr #(.reset_mtvec(csr_reset_mtvec)) u_csr (
    .clock(clock), .reset(reset), .addr(csr_addr), .wen(csr_wen), .wdata(alu_result),
    .trap(trap), .trap_pc(pc), .rdata(csr_rdata), .mtvec(mtvec), .mepc(mepc)
  );

  rv_lsu u_lsu (
    .addr(alu_result), .size(mem_size), .load_signed(load_signed), .store_data(rdata2),
    .mem_rdata(dmem_rdata), .wstrb(lsu_wstrb), .wdata(dmem_wdata), .load_data(load_data)
  );

  always_comb begin
    case (wb_sel)
      wb_pc4:   wb_data = pc_plus4;
      wb_load:  wb_data = load_data;
      wb_auipc: wb_data = pc_plus_imm;
      wb_csr:   wb_data = csr_rdata;
      default:  wb_data = alu_result;
    endcase
  end

  always_comb begin
    case (npc_sel)
      npc_jal:    pc_next = pc_plus_imm;
      npc_jalr:   pc_next = {alu_result[31:1], 1'b0};
      npc_branch: pc_next = taken ? pc_plus_imm : pc_plus4;
      npc_trap:   pc_next = mtvec;
      npc_mret:   pc_next = mepc;
      default:    pc_next = pc_plus4;
    endcase
  end

  assign imem_addr  = pc;
  assign dmem_addr  = alu_result;
  assign dmem_re    = mem_ren;
  assign dmem_we    = mem_wen;
  // strobes only show during a store
  assign dmem_wstrb = mem_wen ? lsu_wstrb : 4'b0000;

endmodule

`default_nettype wire

// File: rv_core_props.sv
`timescale 1ns/100ps
`default_nettype none

module rv_core_props (
  input logic        clock,
  input logic        reset,
  input logic [31:0] imem_addr,
  input logic        dmem_re,
  input logic        dmem_we,
  input logic [3:0]  dmem_wstrb,
  input logic        halted
);

  // a load and a store never share a cycle
  we_re_exclusive: assert property (@(posedge clock) disable iff (reset)
    !(dmem_we && dmem_re))
    else $error("dmem_we and dmem_re high in the same cycle");

  halted_quiet: assert property (@(posedge clock) disable iff (reset)
    halted |-> !dmem_we && !dmem_re && dmem_wstrb == 4'b0000)
    else $error("memory strobe seen while halted");

  // pc sits on the ebreak until the next reset
  pc_holds: assert property (@(posedge clock) disable iff (reset)
    halted |=> $stable(imem_addr))
    else $error("imem_addr moved while halted");

  store_has_strobes: assert property (@(posedge clock) disable iff (reset)
    dmem_we |-> dmem_wstrb != 4'b0000)
    else $error("store without byte strobes");

endmodule

bind rv_core rv_core_props u_props (
  .clock(clock),
  .reset(reset),
  .imem_addr(imem_addr),
  .dmem_re(dmem_re),
  .dmem_we(dmem_we),
  .dmem_wstrb(dmem_wstrb),
  .halted(halted)
);

`default_nettype wire

// File: rv_core_tb.sv
`timescale 1ns/100ps
`default_nettype none

module rv_core_tb
  import rv_pkg::*;
();

  localparam int n_instr      = 3000;
  localparam int max_programs = 60;
  // every program adds reset cycles and one halted cycle to the retired count
  localparam int cycle_limit  = n_instr + max_programs * 10 + 400;

  localparam logic [31:0] inst_ecall  = 32'h0000_0073;
  localparam logic [31:0] inst_ebreak = 32'h0010_0073;
  localparam logic [31:0] inst_mret   = 32'h3020_0073;

  logic        clock;
  logic        reset;
  logic [31:0] imem_addr;
  logic [31:0] imem_data;
  logic [31:0] dmem_addr;
  logic        dmem_re;
  logic [31:0] dmem_rdata;
  logic        dmem_we;
  logic [3:0]  dmem_wstrb;
  logic [31:0] dmem_wdata;
  logic        halted;

  logic [31:0] imem [256];
  logic [31:0] dmem [64];
  logic [31:0] seed = 32'hb1d2_7178;

  // reference model state and the outputs it expects for the current cycle
  logic [31:0] m_x [32];
  logic [31:0] m_pc;
  logic [31:0] m_mtvec;
  logic [31:0] m_mepc;
  logic [31:0] m_mcause;
  logic        m_halted;
  logic        exp_we;
  logic        exp_re;
  logic [3:0]  exp_strb;
  logic [31:0] exp_addr;
  logic [31:0] exp_wdata;

  int retired;
  int cycles = 0;

  rv_core #(.reset_pc(32'h0000_0000), .csr_reset_mtvec(32'h0000_0100)) u_dut (
    .clock(clock), .reset(reset), .imem_addr(imem_addr), .imem_data(imem_data),
    .dmem_addr(dmem_addr), .dmem_re(dmem_re), .dmem_rdata(dmem_rdata), .dmem_we(dmem_we),
    .dmem_wstrb(dmem_wstrb), .dmem_wdata(dmem_wdata), .halted(halted)
  );

  // data memory answers in the same cycle, high address bits wrap
  assign dmem_rdata = dmem[dmem_addr[7:2]];

  initial begin
    clock = 1'b0;
    forever #2 clock = ~clock;
  end

  always @(posedge clock) begin
    cycles <= cycles + 1;
    if (cycles >= cycle_limit) begin
      $display("timeout: the run did not finish within %0d cycles", cycle_limit);
      $display("SIMULATION FAILED");
      $fatal(1, "cycle limit reached");
    end
  end

  function automatic logic [31:0] next_rand();
    seed = seed * 32'd1664525 + 32'd1013904223;
    return seed ^ (seed >> 16);
  endfunction

  task automatic compare_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
    if (got !== exp) begin
      $display("** Error %s: got %h, expected %h", name, got, exp);
      $display("SIMULATION FAILED");
      $fatal(1, "stopping at the first mismatch");
    end
  endtask

  // one legal rv32i word, weighted toward alu and memory operations
  function automatic logic [31:0] random_inst();
    logic [31:0] r;
    logic [31:0] v;
    logic [5:0]  cls;
    logic [4:0]  rd;
    logic [4:0]  rs1;
    logic [4:0]  rs2;
    logic [2:0]  f3;
    logic [2:0]  k;
    logic [11:0] caddr;
    r = next_rand();
    v = next_rand();
    cls = r[31:26];
    rd = r[9:5];
    rs1 = r[14:10];
    rs2 = r[19:15];
    f3 = r[22:20];
    if (cls < 6'd16) begin
      if (f3 == 3'b001) return {7'b0, v[4:0], rs1, f3, rd, opc_op_imm};
      if (f3 == 3'b101) return {1'b0, v[5], 5'b0, v[4:0], rs1, f3, rd, opc_op_imm};
      return {v[11:0], rs1, f3, rd, opc_op_imm};
    end else if (cls < 6'd28) begin
      return {1'b0, v[0] && (f3 == 3'b000 || f3 == 3'b101), 5'b0, rs2, rs1, f3, rd, opc_op};
    end else if (cls < 6'd36) begin
      k = v[14:12] % 3'd5;
      f3 = (k < 3'd3) ? k : k + 3'd1;
      return {v[11:0], rs1, f3, rd, opc_load};
    end else if (cls < 6'd44) begin
      f3 = {1'b0, (v[13:12] == 2'b11) ? 2'b10 : v[13:12]};
      return {v[11:5], rs2, rs1, f3, v[4:0], opc_store};
    end else if (cls < 6'd50) begin
      if (f3[2:1] == 2'b01) f3 = {2'b11, f3[0]};
      return {v[11], v[9:4], rs2, rs1, f3, v[3:0], v[10], opc_branch};
    end else if (cls < 6'd52) begin
      return {v[19:0], rd, opc_jal};
    end else if (cls < 6'd54) begin
      return {v[11:0], rs1, 3'b000, rd, opc_jalr};
    end else if (cls < 6'd56) begin
      return {v[31:12], rd, opc_lui};
    end else if (cls < 6'd58) begin
      return {v[31:12], rd, opc_auipc};
    end else if (cls < 6'd62) begin
      f3 = (r[21:20] == 2'b00) ? 3'b001 : {1'b0, r[21:20]};
      case (v[1:0])
        2'd0:    caddr = csr_mtvec;
        2'd1:    caddr = csr_mepc;
        2'd2:    caddr = csr_mcause;
        default: caddr = 12'h300;
      endcase
      return {caddr, rs1, f3, rd, opc_system};
    end else if (cls == 6'd62) begin
      return inst_ecall;
    end
    return v[0] ? inst_mret : inst_ebreak;
  endfunction

  function automatic logic [31:0] arith_result(input logic [2:0] f3, input logic sub,
                                               input logic arith, input logic [31:0] a,
                                               input logic [31:0] b);
    case (f3)
      3'b000:  return sub ? a - b : a + b;
      3'b001:  return a << b[4:0];
      3'b010:  return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
      3'b011:  return (a < b) ? 32'd1 : 32'd0;
      3'b100:  return a ^ b;
      3'b101:  return arith ? $unsigned($signed(a) >>> b[4:0]) : a >> b[4:0];
      3'b110:  return a | b;
      default: return a & b;
    endcase
  endfunction

  task automatic reset_model();
    for (int i = 0; i < 32; i++) begin
      m_x[i] = 32'd0;
    end
    m_pc = 32'd0;
    m_mtvec = 32'h0000_0100;
    m_mepc = 32'd0;
    m_mcause = 32'd0;
    m_halted = 1'b0;
  endtask

  // executes one instruction on the model, the store itself is applied later
  task automatic step_model(input logic [31:0] inst);
    logic [2:0]  f3;
    logic [4:0]  rd;
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] i_imm;
    logic [31:0] npc;
    logic [31:0] res;
    logic [31:0] lane;
    logic [31:0] old;
    logic [31:0] wval;
    logic        wr;
    logic        cond;
    f3 = inst[14:12];
    rd = inst[11:7];
    a = m_x[inst[19:15]];
    b = m_x[inst[24:20]];
    i_imm = {{20{inst[31]}}, inst[31:20]};
    npc = m_pc + 32'd4;
    res = 32'd0;
    wr = 1'b0;
    exp_we = 1'b0;
    exp_re = 1'b0;
    exp_strb = 4'b0000;
    exp_addr = 32'd0;
    exp_wdata = 32'd0;
    case (inst[6:0])
      opc_lui: begin
        res = {inst[31:12], 12'd0};
        wr = 1'b1;
      end
      opc_auipc: begin
        res = m_pc + {inst[31:12], 12'd0};
        wr = 1'b1;
      end
      opc_jal: begin
        res = m_pc + 32'd4;
        wr = 1'b1;
        npc = m_pc + {{12{inst[31]}}, inst[19:12], inst[20], inst[30:21], 1'b0};
      end
      opc_jalr: begin
        res = m_pc + 32'd4;
        wr = 1'b1;
        npc = (a + i_imm) & ~32'd1;
      end
      opc_branch: begin
        case (f3)
          3'b000:  cond = a == b;
          3'b001:  cond = a != b;
          3'b100:  cond = $signed(a) < $signed(b);
          3'b101:  cond = $signed(a) >= $signed(b);
          3'b110:  cond = a < b;
          default: cond = a >= b;
        endcase
        if (cond) npc = m_pc + {{20{inst[31]}}, inst[7], inst[30:25], inst[11:8], 1'b0};
      end
      opc_load: begin
        exp_re = 1'b1;
        exp_addr = a + i_imm;
        wr = 1'b1;
        lane = dmem[exp_addr[7:2]];
        case (f3[1:0])
          2'b00: begin
            lane = lane >> {exp_addr[1:0], 3'b000};
            res = {{24{~f3[2] & lane[7]}}, lane[7:0]};
          end
          2'b01: begin
            lane = lane >> {exp_addr[1], 4'b0000};
            res = {{16{~f3[2] & lane[15]}}, lane[15:0]};
          end
          default: res = lane;
        endcase
      end
      opc_store: begin
        exp_we = 1'b1;
        exp_addr = a + {{20{inst[31]}}, inst[31:25], inst[11:7]};
        case (f3)
          3'b000: begin
            exp_strb = 4'b0001 << exp_addr[1:0];
            exp_wdata = {4{b[7:0]}};
          end
          3'b001: begin
            exp_strb = exp_addr[1] ? 4'b1100 : 4'b0011;
            exp_wdata = {2{b[15:0]}};
          end
          default: begin
            exp_strb = 4'b1111;
            exp_wdata = b;
          end
        endcase
      end
      opc_op_imm: begin
        res = arith_result(f3, 1'b0, inst[30], a, i_imm);
        wr = 1'b1;
      end
      opc_op: begin
        res = arith_result(f3, inst[30], inst[30], a, b);
        wr = 1'b1;
      end
      opc_system: begin
        if (inst == inst_ecall) begin
          m_mepc = m_pc;
          m_mcause = 32'd11;
          npc = m_mtvec;
        end else if (inst == inst_mret) begin
          npc = m_mepc;
        end else if (inst == inst_ebreak) begin
          m_halted = 1'b1;
          npc = m_pc;
        end else begin
          case (inst[31:20])
            csr_mtvec:  old = m_mtvec;
            csr_mepc:   old = m_mepc;
            csr_mcause: old = m_mcause;
            default:    old = 32'd0;
          endcase
          case (f3)
            3'b001:  wval = a;
            3'b010:  wval = old | a;
            default: wval = old & ~a;
          endcase
          case (inst[31:20])
            csr_mtvec:  m_mtvec = wval;
            csr_mepc:   m_mepc = wval;
            csr_mcause: m_mcause = wval;
            default:    ;
          endcase
          res = old;
          wr = 1'b1;
        end
      end
      default: ;
    endcase
    if (wr && rd != 5'd0) m_x[rd] = res;
    m_pc = npc;
  endtask

  task automatic apply_store();
    for (int k = 0; k < 4; k++) begin
      if (exp_strb[k]) dmem[exp_addr[7:2]][8*k +: 8] = exp_wdata[8*k +: 8];
    end
  endtask

  // fresh program and data, reset, then run until halt or the instruction budget
  task automatic run_program();
    logic done;
    for (int k = 0; k < 256; k++) begin
      imem[k] = random_inst();
    end
    imem[64] = inst_ebreak;
    imem[255] = inst_ebreak;
    for (int k = 0; k < 64; k++) begin
      dmem[k] = next_rand();
    end
    reset_model();
    reset = 1'b1;
    imem_data = 32'd0;
    repeat (4) @(posedge clock);
    @(negedge clock);
    compare_value("imem_addr", imem_addr, 32'd0);
    compare_value("halted", 32'(halted), 32'd0);
    compare_value("dmem_we", 32'(dmem_we), 32'd0);
    compare_value("dmem_re", 32'(dmem_re), 32'd0);
    reset = 1'b0;
    imem_data = imem[imem_addr[9:2]];
    done = 1'b0;
    while (!done && retired < n_instr) begin
      #1;
      compare_value("imem_addr", imem_addr, m_pc);
      compare_value("halted", 32'(halted), 32'(m_halted));
      if (m_halted) begin
        compare_value("dmem_we", 32'(dmem_we), 32'd0);
        compare_value("dmem_re", 32'(dmem_re), 32'd0);
        compare_value("dmem_wstrb", 32'(dmem_wstrb), 32'd0);
        done = 1'b1;
      end else begin
        step_model(imem[imem_addr[9:2]]);
        compare_value("dmem_we", 32'(dmem_we), 32'(exp_we));
        compare_value("dmem_re", 32'(dmem_re), 32'(exp_re));
        compare_value("dmem_wstrb", 32'(dmem_wstrb), 32'(exp_strb));
        if (exp_we || exp_re) compare_value("dmem_addr", dmem_addr, exp_addr);
        if (exp_we) begin
          compare_value("dmem_wdata", dmem_wdata, exp_wdata);
          apply_store();
        end
        retired++;
      end
      @(negedge clock);
      imem_data = imem[imem_addr[9:2]];
    end
  endtask

  initial begin
    int programs;
    reset = 1'b1;
    imem_data = 32'd0;
    retired = 0;
    programs = 0;
    while (retired < n_instr && programs < max_programs) begin
      run_program();
      programs++;
    end
    $display("%0d instructions matched over %0d programs", retired, programs);
    $display("SIMULATION PASSED");
    $finish;
  end

endmodule

`default_nettype wire

// File: src.f
rv_pkg.sv
rv_alu.sv
rv_regfile.sv
rv_csr.sv
rv_lsu.sv
rv_idu.sv
rv_core.sv
rv_core_props.sv
rv_core_tb.sv

// File: run.sh
#!/bin/sh
# compile and run the rv_core testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module rv_core_tb -Mdir obj_dir -f src.f

status=0
./obj_dir/Vrv_core_tb > sim.log 2>&1 || status=$?
cat sim.log

if [ "$status" -ne 0 ] || grep -q "SIMULATION FAILED" sim.log; then
  echo "run failed, see sim.log"
  exit 1
fi
echo "run finished without failure"
